// File: Bender.yml
package:
  name: rca_top

sources:
  - rca_grid_pkg.sv
  - rca_config_pkg.sv
  - grid_io_block.sv
  - rca_pr_grid.sv
  - rca_wb_fifo.sv
  - rca_wb_commit.sv
  - rca_top.sv
  - target: test
    files:
      - rca_top_tb.sv

// File: grid_io_block.sv
`timescale 1ns/1ps

module grid_io_block (
    input  logic                        clk,
    input  logic                        arst_n,
    input  rca_grid_pkg::grid_token_t   in_token,
    input  rca_config_pkg::io_op_t      op,
    output rca_grid_pkg::grid_token_t   out_token
);

    rca_grid_pkg::xlen_t op_result;
    rca_grid_pkg::xlen_t data_q;
    logic                valid_q;

    // One-cycle operation on the selected input
    always_comb begin
        op_result = in_token.data;
        case (op)
            rca_config_pkg::IO_OP_PASS: op_result = in_token.data;
            rca_config_pkg::IO_OP_NEG:  op_result = -in_token.data;
            rca_config_pkg::IO_OP_SHL1: op_result = in_token.data << 1;
            rca_config_pkg::IO_OP_INC:  op_result = in_token.data + 1'b1;
            default:                    op_result = in_token.data;
        endcase
    end

    // Valid follows the input every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_token.valid;
        end
    end

    // Result only captured for a valid operand
    always_ff @(posedge clk) begin
        if (in_token.valid) begin
            data_q <= op_result;
        end
    end

    assign out_token.valid = valid_q;
    assign out_token.data  = data_q;

    // A valid operand needs a defined operation or the row result is garbage
    a_op_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        in_token.valid |-> !$isunknown(op)
    ) else $error("grid_io_block: unknown op with valid input");

endmodule

// File: rca_config_pkg.sv
package rca_config_pkg;

    // Mux inputs per row: rs0, rs1 and the row above
    localparam int IO_UNIT_MUX_INPUTS = 3;
    localparam int IO_SEL_W = $clog2(IO_UNIT_MUX_INPUTS);

    // Select values 0 and 1 pick a core operand, 2 picks the chain
    typedef logic [IO_SEL_W-1:0] io_sel_t;

    // IO unit operation
    localparam int IO_OP_W = 2;
    typedef logic [IO_OP_W-1:0] io_op_t;

    localparam io_op_t IO_OP_PASS = 2'd0;
    localparam io_op_t IO_OP_NEG  = 2'd1;
    localparam io_op_t IO_OP_SHL1 = 2'd2;
    localparam io_op_t IO_OP_INC  = 2'd3;

    // Index of a grid row
    localparam int ROW_SEL_W = $clog2(rca_grid_pkg::GRID_NUM_ROWS);
    typedef logic [ROW_SEL_W-1:0] row_sel_t;

    // Static grid configuration, 20 bits
    typedef struct packed {
        io_sel_t  [rca_grid_pkg::GRID_NUM_ROWS-1:0]   io_mux_sel;
        io_op_t   [rca_grid_pkg::GRID_NUM_ROWS-1:0]   io_op;
        row_sel_t [rca_grid_pkg::NUM_WRITE_PORTS-1:0] wb_row_sel;
    } rca_grid_cfg_t;

endpackage

// File: rca_grid_pkg.sv
package rca_grid_pkg;

    // Datapath width, matches the core register file
    localparam int XLEN = 32;

    // Grid geometry
    localparam int GRID_NUM_ROWS = 4;

    // Core operand and result ports
    localparam int NUM_READ_PORTS = 2;
    localparam int NUM_WRITE_PORTS = 2;

    // Entries per writeback FIFO
    localparam int WB_FIFO_DEPTH = 4;

    // One data word
    typedef logic [XLEN-1:0] xlen_t;

    // Data word with its valid strobe
    // Row results, FIFO entries and write port outputs all use this
    typedef struct packed {
        logic  valid;
        xlen_t data;
    } grid_token_t;

endpackage

// File: rca_pr_grid.sv
`timescale 1ns/1ps

module rca_pr_grid (
    input  logic                          clk,
    input  logic                          arst_n,
    input  rca_grid_pkg::xlen_t           rs_vals [rca_grid_pkg::NUM_READ_PORTS],
    input  logic [rca_grid_pkg::GRID_NUM_ROWS-1:0] data_valid,
    input  rca_config_pkg::rca_grid_cfg_t cfg,
    output rca_grid_pkg::grid_token_t     row_tokens [rca_grid_pkg::GRID_NUM_ROWS]
);

    genvar k;

    generate
        for (k = 0; k < rca_grid_pkg::GRID_NUM_ROWS; k++) begin : g_row
            rca_grid_pkg::grid_token_t mux_in [rca_config_pkg::IO_UNIT_MUX_INPUTS];
            rca_grid_pkg::grid_token_t chain_in;
            rca_grid_pkg::grid_token_t sel_token;

            // First row has nothing above it
            if (k == 0) begin : g_chain_first
                assign chain_in = '0;
            end else begin : g_chain_prev
                assign chain_in = row_tokens[k-1];
            end

            // Core operands share this row's valid strobe
            always_comb begin
                for (int i = 0; i < rca_grid_pkg::NUM_READ_PORTS; i++) begin
                    mux_in[i].valid = data_valid[k];
                    mux_in[i].data  = rs_vals[i];
                end
                for (int j = rca_grid_pkg::NUM_READ_PORTS;
                     j < rca_config_pkg::IO_UNIT_MUX_INPUTS; j++) begin
                    mux_in[j] = chain_in;
                end
            end

            // Input crossbar, out-of-range selects give an idle row
            always_comb begin
                sel_token = '0;
                if (cfg.io_mux_sel[k] < rca_config_pkg::IO_UNIT_MUX_INPUTS) begin
                    sel_token = mux_in[cfg.io_mux_sel[k]];
                end
            end

            grid_io_block u_io_unit (
                .clk       (clk),
                .arst_n    (arst_n),
                .in_token  (sel_token),
                .op        (cfg.io_op[k]),
                .out_token (row_tokens[k])
            );

            a_sel_in_range: assert property (
                @(posedge clk) disable iff (!arst_n)
                cfg.io_mux_sel[k] < rca_config_pkg::IO_UNIT_MUX_INPUTS
            ) else $error("rca_pr_grid: row %0d mux select out of range", k);
        end
    endgenerate

endmodule

// File: rca_top.f
rca_grid_pkg.sv
rca_config_pkg.sv
grid_io_block.sv
rca_pr_grid.sv
rca_wb_fifo.sv
rca_wb_commit.sv
rca_top.sv
rca_top_tb.sv

// File: rca_top.sv
`timescale 1ns/1ps

module rca_top (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  rca_grid_pkg::xlen_t                      rs_vals [rca_grid_pkg::NUM_READ_PORTS],
    input  logic [rca_grid_pkg::GRID_NUM_ROWS-1:0]   data_valid,
    input  rca_config_pkg::rca_grid_cfg_t            cfg,
    input  logic                                     wb_stall,
    output rca_grid_pkg::grid_token_t                rd_tokens [rca_grid_pkg::NUM_WRITE_PORTS],
    output logic [rca_grid_pkg::NUM_WRITE_PORTS-1:0] wb_overflow
);

    rca_grid_pkg::grid_token_t                row_tokens [rca_grid_pkg::GRID_NUM_ROWS];
    rca_grid_pkg::grid_token_t                push_tokens [rca_grid_pkg::NUM_WRITE_PORTS];
    rca_grid_pkg::xlen_t                      fifo_head [rca_grid_pkg::NUM_WRITE_PORTS];
    logic [rca_grid_pkg::NUM_WRITE_PORTS-1:0] fifo_empty;
    logic [rca_grid_pkg::NUM_WRITE_PORTS-1:0] fifo_pop;

    genvar p;

    rca_pr_grid u_grid (
        .clk        (clk),
        .arst_n     (arst_n),
        .rs_vals    (rs_vals),
        .data_valid (data_valid),
        .cfg        (cfg),
        .row_tokens (row_tokens)
    );

    generate
        for (p = 0; p < rca_grid_pkg::NUM_WRITE_PORTS; p++) begin : g_wb
            // Configured row feeds this write port
            assign push_tokens[p] = row_tokens[cfg.wb_row_sel[p]];

            rca_wb_fifo u_fifo (
                .clk        (clk),
                .arst_n     (arst_n),
                .push_token (push_tokens[p]),
                .pop        (fifo_pop[p]),
                .head       (fifo_head[p]),
                .empty      (fifo_empty[p]),
                .overflow   (wb_overflow[p])
            );
        end
    endgenerate

    rca_wb_commit u_commit (
        .clk       (clk),
        .arst_n    (arst_n),
        .head      (fifo_head),
        .empty     (fifo_empty),
        .wb_stall  (wb_stall),
        .pop       (fifo_pop),
        .rd_tokens (rd_tokens)
    );

endmodule

// File: rca_top_tb.sv
`timescale 1ns/1ps

module rca_top_tb;

    localparam int CLK_PERIOD = 100;
    localparam int WAIT_LIMIT = 20;
    localparam int NUM_PORTS  = rca_grid_pkg::NUM_WRITE_PORTS;

    logic                                   clk;
    logic                                   arst_n;
    rca_grid_pkg::xlen_t                    rs_vals [rca_grid_pkg::NUM_READ_PORTS];
    logic [rca_grid_pkg::GRID_NUM_ROWS-1:0] data_valid;
    rca_config_pkg::rca_grid_cfg_t          cfg;
    logic                                   wb_stall;
    rca_grid_pkg::grid_token_t              rd_tokens [NUM_PORTS];
    logic [NUM_PORTS-1:0]                   wb_overflow;

    rca_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .rs_vals     (rs_vals),
        .data_valid  (data_valid),
        .cfg         (cfg),
        .wb_stall    (wb_stall),
        .rd_tokens   (rd_tokens),
        .wb_overflow (wb_overflow)
    );

    always begin
        #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Reference behaviour of one IO unit
    function automatic rca_grid_pkg::xlen_t apply_op(input rca_config_pkg::io_op_t op,
                                                     input rca_grid_pkg::xlen_t x);
        case (op)
            rca_config_pkg::IO_OP_NEG:  return ~x + 32'd1;
            rca_config_pkg::IO_OP_SHL1: return {x[rca_grid_pkg::XLEN-2:0], 1'b0};
            rca_config_pkg::IO_OP_INC:  return x + 32'd1;
            default:                    return x;
        endcase
    endfunction

    // Row where the chain ending in row picks up its core operand
    function automatic int chain_start(input int row);
        int r;
        r = row;
        while (r > 0 && cfg.io_mux_sel[r] == 2'd2) begin
            r--;
        end
        return r;
    endfunction

    function automatic rca_grid_pkg::xlen_t model_row(input int row,
                                                      input rca_grid_pkg::xlen_t rs0,
                                                      input rca_grid_pkg::xlen_t rs1);
        int                  first;
        rca_grid_pkg::xlen_t val;
        first = chain_start(row);
        val = (cfg.io_mux_sel[first] == 2'd1) ? rs1 : rs0;
        for (int r = first; r <= row; r++) begin
            val = apply_op(cfg.io_op[r], val);
        end
        return val;
    endfunction

    task automatic expect_silence(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                check_hex($sformatf("rd_tokens[%0d].valid", p), rd_tokens[p].valid, 1'b0);
            end
        end
    endtask

    // Back-to-back operands, each result checked for order, data and exact latency
    task automatic stream_operands(input int port, input int n);
        rca_grid_pkg::xlen_t exp_q [$];
        int                  due_q [$];
        int                  row;
        int                  first;
        int                  latency;
        int                  sent;
        rca_grid_pkg::xlen_t exp_data;
        int                  due;
        row = cfg.wb_row_sel[port];
        first = chain_start(row);
        // One cycle per row hop, then FIFO write and commit
        latency = row - first + 3;
        sent = 0;
        for (int cyc = 0; cyc < n + latency + WAIT_LIMIT; cyc++) begin
            @(negedge clk);
            if (rd_tokens[port].valid) begin
                assert (exp_q.size() > 0) else begin
                    abort_run($sformatf("Unexpected write on port %0d", port));
                end
                exp_data = exp_q.pop_front();
                due = due_q.pop_front();
                check_hex($sformatf("rd_tokens[%0d].valid cycle", port), cyc, due);
                check_hex($sformatf("rd_tokens[%0d].data", port), rd_tokens[port].data, exp_data);
            end
            if (sent == n && exp_q.size() == 0) begin
                break;
            end
            if (sent < n) begin
                rs_vals[0] = $urandom();
                rs_vals[1] = $urandom();
                data_valid = '0;
                data_valid[first] = 1'b1;
                exp_q.push_back(model_row(row, rs_vals[0], rs_vals[1]));
                due_q.push_back(cyc + latency);
                sent++;
            end else begin
                data_valid = '0;
            end
        end
        assert (sent == n && exp_q.size() == 0) else begin
            abort_run($sformatf("Timed out waiting for results on port %0d", port));
        end
    endtask

    task automatic drive_idle_operands(input logic [3:0] mask, input int n);
        repeat (n) begin
            @(negedge clk);
            rs_vals[0] = $urandom();
            rs_vals[1] = $urandom();
            data_valid = mask;
        end
        @(negedge clk);
        data_valid = '0;
    endtask

    // Pushes under stall, then releases and expects the first n_keep in order
    task automatic stall_and_drain(input int port, input int n_push, input int n_keep);
        rca_grid_pkg::xlen_t exp_q [$];
        int                  row;
        int                  waited;
        row = cfg.wb_row_sel[port];
        @(negedge clk);
        wb_stall = 1'b1;
        for (int i = 0; i < n_push; i++) begin
            rs_vals[0] = $urandom();
            rs_vals[1] = $urandom();
            data_valid = '0;
            data_valid[chain_start(row)] = 1'b1;
            if (exp_q.size() < n_keep) begin
                exp_q.push_back(model_row(row, rs_vals[0], rs_vals[1]));
            end
            @(negedge clk);
        end
        data_valid = '0;
        expect_silence(6);
        wb_stall = 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!rd_tokens[port].valid && waited < WAIT_LIMIT);
        assert (rd_tokens[port].valid) else begin
            abort_run($sformatf("Timed out waiting for drain of port %0d", port));
        end
        for (int i = 0; i < n_keep; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            check_hex($sformatf("rd_tokens[%0d].valid", port), rd_tokens[port].valid, 1'b1);
            check_hex($sformatf("rd_tokens[%0d].data", port), rd_tokens[port].data, exp_q[i]);
        end
        expect_silence(10);
    endtask

    task automatic reset_state();
        @(negedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_hex($sformatf("rd_tokens[%0d].valid", p), rd_tokens[p].valid, 1'b0);
            check_hex($sformatf("wb_overflow[%0d]", p), wb_overflow[p], 1'b0);
        end
    endtask

    task automatic direct_path();
        cfg = '0;
        cfg.io_op[0] = rca_config_pkg::IO_OP_PASS;
        cfg.wb_row_sel[1] = 2'd1;
        stream_operands(0, 10);
    endtask

    task automatic chained_ops();
        cfg = '0;
        cfg.io_mux_sel[0] = 2'd1;
        cfg.io_op[0] = rca_config_pkg::IO_OP_INC;
        cfg.io_mux_sel[1] = 2'd2;
        cfg.io_op[1] = rca_config_pkg::IO_OP_NEG;
        cfg.io_mux_sel[2] = 2'd2;
        cfg.io_op[2] = rca_config_pkg::IO_OP_SHL1;
        cfg.wb_row_sel[0] = 2'd3;
        cfg.wb_row_sel[1] = 2'd2;
        stream_operands(1, 10);
    endtask

    task automatic valid_gating();
        // Row 0 strobe low while the other rows see valid operands
        cfg = '0;
        drive_idle_operands(4'b1110, 4);
        expect_silence(10);
        // Row 1 reads the chain from an idle row 0
        cfg.io_mux_sel[1] = 2'd2;
        cfg.wb_row_sel[0] = 2'd1;
        cfg.wb_row_sel[1] = 2'd1;
        drive_idle_operands(4'b1110, 4);
        expect_silence(10);
    endtask

    task automatic stall_release();
        cfg = '0;
        cfg.wb_row_sel[1] = 2'd1;
        stall_and_drain(0, rca_grid_pkg::WB_FIFO_DEPTH, rca_grid_pkg::WB_FIFO_DEPTH);
        check_hex("wb_overflow", wb_overflow, 2'b00);
    endtask

    task automatic overflow_drop();
        cfg = '0;
        cfg.wb_row_sel[0] = 2'd1;
        stall_and_drain(1, rca_grid_pkg::WB_FIFO_DEPTH + 2, rca_grid_pkg::WB_FIFO_DEPTH);
        check_hex("wb_overflow[1]", wb_overflow[1], 1'b1);
        check_hex("wb_overflow[0]", wb_overflow[0], 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        rs_vals[0] = '0;
        rs_vals[1] = '0;
        data_valid = '0;
        cfg = '0;
        wb_stall = 1'b0;
        void'($urandom(32'hd1ac));
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        reset_state();
        direct_path();
        chained_ops();
        valid_gating();
        stall_release();
        overflow_drop();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: rca_wb_commit.sv
`timescale 1ns/1ps

module rca_wb_commit (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  rca_grid_pkg::xlen_t                      head [rca_grid_pkg::NUM_WRITE_PORTS],
    input  logic [rca_grid_pkg::NUM_WRITE_PORTS-1:0] empty,
    input  logic                                     wb_stall,
    output logic [rca_grid_pkg::NUM_WRITE_PORTS-1:0] pop,
    output rca_grid_pkg::grid_token_t                rd_tokens [rca_grid_pkg::NUM_WRITE_PORTS]
);

    genvar p;

    generate
        for (p = 0; p < rca_grid_pkg::NUM_WRITE_PORTS; p++) begin : g_port
            logic                valid_q;
            rca_grid_pkg::xlen_t data_q;

            // Drain one entry per cycle unless the core holds writeback
            assign pop[p] = !empty[p] && !wb_stall;

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    valid_q <= 1'b0;
                end else begin
                    valid_q <= pop[p];
                end
            end

            always_ff @(posedge clk) begin
                if (pop[p]) begin
                    data_q <= head[p];
                end
            end

            assign rd_tokens[p].valid = valid_q;
            assign rd_tokens[p].data  = data_q;

            // Every committed write carries a defined value from a written FIFO slot
            a_wb_data_known: assert property (
                @(posedge clk) disable iff (!arst_n)
                rd_tokens[p].valid |-> !$isunknown(rd_tokens[p].data)
            ) else $error("rca_wb_commit: port %0d wrote unknown data", p);
        end
    endgenerate

endmodule

// File: rca_wb_fifo.sv
`timescale 1ns/1ps

module rca_wb_fifo (
    input  logic                      clk,
    input  logic                      arst_n,
    input  rca_grid_pkg::grid_token_t push_token,
    input  logic                      pop,
    output rca_grid_pkg::xlen_t       head,
    output logic                      empty,
    output logic                      overflow
);

    rca_grid_pkg::xlen_t mem [rca_grid_pkg::WB_FIFO_DEPTH];

    logic [$clog2(rca_grid_pkg::WB_FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(rca_grid_pkg::WB_FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(rca_grid_pkg::WB_FIFO_DEPTH+1)-1:0] count;
    logic                                             full;
    logic                                             push;

    assign full  = (count == rca_grid_pkg::WB_FIFO_DEPTH);
    assign empty = (count == '0);

    // A pop in the same cycle frees the slot being written
    assign push = push_token.valid && (!full || pop);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == rca_grid_pkg::WB_FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == rca_grid_pkg::WB_FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (!push && pop) begin
                count <= count - 1'b1;
            end
            // Sticky until reset
            if (push_token.valid && !push) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_token.data;
        end
    end

    // Show-ahead, oldest entry always visible
    assign head = mem[rd_ptr];

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!arst_n)
        pop |-> !empty
    ) else $error("rca_wb_fifo: pop while empty");

endmodule
